/* design/game_pkg.sv */
package game_pkg;

    //============================================================
    // game constants
    //============================================================
    localparam int EVENT_COUNT    = 13;   // one per command kind
    localparam int FIFO_DEPTH     = 8;

    localparam int SCREEN_W       = 640;
    localparam int SCREEN_H       = 480;
    localparam int PLAYER_START_X = 320;
    localparam int PLAYER_START_Y = 240;
    localparam int MOVE_STEP      = 5;    // also the edge margin

    localparam int VOL_MIN        = 1;
    localparam int VOL_MAX        = 5;
    localparam int VOL_RESET      = 3;

    localparam int SCORE_MAX      = 99;
    localparam int WIN_SCORE      = 10;
    localparam int HEALTH_START   = 50;
    localparam int PLAYER_DAMAGE  = 2;

    //============================================================
    // types
    //============================================================
    typedef enum logic [2:0] {
        menu_idle,
        menu_tutorial,
        game_running,
        game_win,
        game_pause,
        game_lose
    } game_state_t;

    // order sets the encoder priority, lowest first
    typedef enum logic [3:0] {
        cmd_move_up,
        cmd_move_down,
        cmd_move_left,
        cmd_move_right,
        cmd_btn_up,
        cmd_btn_down,
        cmd_select,
        cmd_back,
        cmd_pause_on,
        cmd_pause_off,
        cmd_hit_enemy,
        cmd_hit_shooter,
        cmd_hit_player
    } cmd_kind_t;

    typedef struct packed {
        logic key_w;
        logic key_a;
        logic key_s;
        logic key_d;
        logic btn_up;
        logic btn_down;
        logic btn_select;
        logic btn_back;
        logic pause_sw;
        logic hit_enemy;
        logic hit_shooter;
        logic hit_player;
    } raw_inputs_t;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        game_state_t state;
        logic [3:0]  volume;
        logic [7:0]  score;
        logic [7:0]  health;
        pos_t        pos;
    } core_status_t;

endpackage

/* design/cmd_encoder.sv */
`timescale 1ns/1ps

module cmd_encoder (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::raw_inputs_t  inputs,
    output logic                   cmd_valid,
    output game_pkg::cmd_kind_t    cmd,
    input  logic                   cmd_ready
);
    import game_pkg::*;

    raw_inputs_t             prev;       // levels from the last cycle
    logic [EVENT_COUNT-1:0]  pending;    // seen but not yet presented
    logic [EVENT_COUNT-1:0]  edges;
    logic [EVENT_COUNT-1:0]  avail;
    cmd_kind_t               pick_kind;
    logic                    pick_any;
    logic                    load;

    //============================================================
    // edge detection
    //============================================================
    always_comb begin
        raw_inputs_t rise;
        raw_inputs_t fall;
        rise = inputs & ~prev;
        fall = ~inputs & prev;
        edges = '0;
        edges[cmd_move_up]     = rise.key_w;
        edges[cmd_move_down]   = rise.key_s;
        edges[cmd_move_left]   = rise.key_a;
        edges[cmd_move_right]  = rise.key_d;
        edges[cmd_btn_up]      = rise.btn_up;
        edges[cmd_btn_down]    = rise.btn_down;
        edges[cmd_select]      = rise.btn_select;
        edges[cmd_back]        = rise.btn_back;
        edges[cmd_pause_on]    = rise.pause_sw;
        edges[cmd_pause_off]   = fall.pause_sw;    // switch released
        edges[cmd_hit_enemy]   = rise.hit_enemy;
        edges[cmd_hit_shooter] = rise.hit_shooter;
        edges[cmd_hit_player]  = rise.hit_player;
        // same kind still waiting at the output, fold it in
        if (cmd_valid && !cmd_ready) begin
            edges[cmd] = 1'b0;
        end
    end

    assign avail = pending | edges;
    assign load  = !cmd_valid || cmd_ready;   // output slot free this edge

    // fixed priority, lowest kind wins
    always_comb begin
        pick_any  = |avail;
        pick_kind = cmd_move_up;
        for (int i = EVENT_COUNT - 1; i >= 0; i--) begin
            if (avail[i]) pick_kind = cmd_kind_t'(4'(i));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev      <= '0;
            pending   <= '0;
            cmd_valid <= 1'b0;
            cmd       <= cmd_move_up;
        end else begin
            prev <= inputs;
            if (load) begin
                cmd_valid <= pick_any;
                cmd       <= pick_kind;
                pending   <= avail;
                if (pick_any) pending[pick_kind] <= 1'b0;
            end else begin
                pending <= avail;    // hold output, keep collecting
            end
        end
    end

endmodule

/* design/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  game_pkg::cmd_kind_t  in_cmd,
    output logic                 out_valid,
    input  logic                 out_ready,
    output game_pkg::cmd_kind_t  out_cmd
);
    import game_pkg::*;

    cmd_kind_t                       mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]     count;
    logic                            do_write;
    logic                            do_read;

    assign in_ready  = (count != FIFO_DEPTH);
    assign out_valid = (count != 0);
    assign out_cmd   = mem[rd_ptr];

    assign do_write = in_valid && in_ready;
    assign do_read  = out_valid && out_ready;

    // storage
    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= in_cmd;
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

/* design/game_core.sv */
`timescale 1ns/1ps

module game_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  game_pkg::cmd_kind_t    cmd,
    output game_pkg::core_status_t status
);
    import game_pkg::*;

    game_state_t  state;
    logic         menu_sel;       // 0 start game, 1 tutorial
    logic         entry;          // first cycle of a new game
    logic [3:0]   volume;
    logic [7:0]   score;
    logic [7:0]   health;
    pos_t         pos;
    logic         accept;
    logic [7:0]   score_enemy;
    logic [7:0]   score_shooter;
    logic [7:0]   health_hit;

    assign cmd_ready = !entry;
    assign accept    = cmd_valid && cmd_ready;

    // saturated hit results
    always_comb begin
        score_enemy   = (score >= 8'(SCORE_MAX - 1)) ? 8'(SCORE_MAX) : score + 8'd1;
        score_shooter = (score >= 8'(SCORE_MAX - 2)) ? 8'(SCORE_MAX) : score + 8'd2;
        health_hit    = (health > 8'(PLAYER_DAMAGE)) ? health - 8'(PLAYER_DAMAGE) : 8'd0;
    end

    //============================================================
    // state machine and play state
    //============================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= menu_idle;
            menu_sel <= 1'b0;
            entry    <= 1'b0;
            volume   <= 4'(VOL_RESET);
            score    <= '0;
            health   <= 8'(HEALTH_START);
            pos.x    <= coord_t'(PLAYER_START_X);
            pos.y    <= coord_t'(PLAYER_START_Y);
        end else if (entry) begin
            // fresh game, nothing consumed this cycle
            entry  <= 1'b0;
            score  <= '0;
            health <= 8'(HEALTH_START);
            pos.x  <= coord_t'(PLAYER_START_X);
            pos.y  <= coord_t'(PLAYER_START_Y);
        end else if (accept) begin
            case (state)
                menu_idle: begin
                    if (cmd == cmd_btn_up) menu_sel <= 1'b0;
                    if (cmd == cmd_btn_down) menu_sel <= 1'b1;
                    if (cmd == cmd_select) begin
                        state <= menu_sel ? menu_tutorial : game_running;
                        entry <= !menu_sel;
                    end
                end
                game_running: begin
                    case (cmd)
                        cmd_move_up:
                            if (pos.y >= coord_t'(2 * MOVE_STEP))
                                pos.y <= pos.y - coord_t'(MOVE_STEP);
                        cmd_move_down:
                            if (pos.y <= coord_t'(SCREEN_H - 2 * MOVE_STEP))
                                pos.y <= pos.y + coord_t'(MOVE_STEP);
                        cmd_move_left:
                            if (pos.x >= coord_t'(2 * MOVE_STEP))
                                pos.x <= pos.x - coord_t'(MOVE_STEP);
                        cmd_move_right:
                            if (pos.x <= coord_t'(SCREEN_W - 2 * MOVE_STEP))
                                pos.x <= pos.x + coord_t'(MOVE_STEP);
                        cmd_btn_up:
                            if (volume < 4'(VOL_MAX)) volume <= volume + 4'd1;
                        cmd_btn_down:
                            if (volume > 4'(VOL_MIN)) volume <= volume - 4'd1;
                        cmd_pause_on:
                            state <= game_pause;
                        cmd_hit_enemy: begin
                            score <= score_enemy;
                            if (score_enemy >= 8'(WIN_SCORE)) state <= game_win;
                        end
                        cmd_hit_shooter: begin
                            score <= score_shooter;
                            if (score_shooter >= 8'(WIN_SCORE)) state <= game_win;
                        end
                        cmd_hit_player: begin
                            health <= health_hit;
                            if (health_hit == 8'd0) state <= game_lose;
                        end
                        default: ;    // dropped
                    endcase
                end
                game_pause: begin
                    if (cmd == cmd_pause_off) state <= game_running;
                end
                menu_tutorial, game_win, game_lose: begin
                    if (cmd == cmd_back) state <= menu_idle;
                end
                default: state <= menu_idle;
            endcase
        end
    end

    always_comb begin
        status.state  = state;
        status.volume = volume;
        status.score  = score;
        status.health = health;
        status.pos    = pos;
    end

endmodule

/* design/status_display.sv */
`timescale 1ns/1ps

module status_display (
    input  logic                   clk,
    input  logic                   rst,
    input  game_pkg::core_status_t status,
    output logic [15:0]            led,
    output logic [15:0]            status_bcd
);
    import game_pkg::*;

    logic [15:0] led_next;
    logic [15:0] bcd_next;

    // volume bar, lit only while a game is on screen
    always_comb begin
        if (status.state == game_running || status.state == game_pause) begin
            led_next = (16'd1 << status.volume) - 16'd1;
        end else begin
            led_next = '0;
        end
    end

    //============================================================
    // health and score digits
    //============================================================
    always_comb begin
        bcd_next = {4'(status.health / 8'd10), 4'(status.health % 8'd10),
                    4'(status.score / 8'd10), 4'(status.score % 8'd10)};
        if (status.state == game_win) begin
            bcd_next = '0;    // blank on win
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led        <= '0;
            status_bcd <= '0;
        end else begin
            led        <= led_next;
            status_bcd <= bcd_next;
        end
    end

endmodule

/* design/game_top.sv */
`timescale 1ns/1ps

module game_top (
    input  logic                  clk,
    input  logic                  rst,
    input  game_pkg::raw_inputs_t inputs,
    output logic [15:0]           led,
    output logic [15:0]           status_bcd,
    output game_pkg::game_state_t game_state,
    output game_pkg::pos_t        player_pos
);
    import game_pkg::*;

    logic          enc_valid;     // encoder to queue
    logic          enc_ready;
    cmd_kind_t     enc_cmd;
    logic          q_valid;       // queue to core
    logic          q_ready;
    cmd_kind_t     q_cmd;
    core_status_t  status;

    cmd_encoder cmd_encoder_i (
        .clk       (clk),
        .rst       (rst),
        .inputs    (inputs),
        .cmd_valid (enc_valid),
        .cmd       (enc_cmd),
        .cmd_ready (enc_ready)
    );

    cmd_fifo cmd_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (enc_valid),
        .in_ready  (enc_ready),
        .in_cmd    (enc_cmd),
        .out_valid (q_valid),
        .out_ready (q_ready),
        .out_cmd   (q_cmd)
    );

    game_core game_core_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (q_valid),
        .cmd_ready (q_ready),
        .cmd       (q_cmd),
        .status    (status)
    );

    status_display status_display_i (
        .clk        (clk),
        .rst        (rst),
        .status     (status),
        .led        (led),
        .status_bcd (status_bcd)
    );

    assign game_state = status.state;
    assign player_pos = status.pos;

endmodule

/* verification/game_props.sv */
`timescale 1ns/1ps

module game_props (
    input logic                                  clk,
    input logic                                  rst,
    input logic                                  out_ready,
    input logic [$clog2(game_pkg::FIFO_DEPTH):0] fifo_count,
    input game_pkg::game_state_t                 game_state,
    input logic [15:0]                           led
);
    import game_pkg::*;

    //============================================================
    // queue, state and volume bar
    //============================================================
    // a full queue can only drain, any write shows up in the count
    assert property (@(posedge clk) disable iff (rst)
        (int'(fifo_count) == FIFO_DEPTH)
            |=> (int'(fifo_count) == FIFO_DEPTH - int'($past(out_ready))))
        else $error("cmd_fifo took a command while full");

    assert property (@(posedge clk) disable iff (rst)
        game_state inside {menu_idle, menu_tutorial, game_running,
                           game_win, game_pause, game_lose})
        else $error("game_state holds an illegal encoding");

    // zero or a solid run of low bits, no wider than the top volume
    assert property (@(posedge clk) disable iff (rst)
        ((led & (led + 16'd1)) == 16'd0) && (led <= 16'((1 << VOL_MAX) - 1)))
        else $error("led is not a contiguous volume bar");

endmodule

/* verification/game_tb.sv */
`timescale 1ns/1ps

module game_tb;
    import game_pkg::*;

    localparam int CLK_HALF   = 2;     // 4 ns period
    localparam int RST_CYCLES = 5;
    localparam int ROW_CYCLES = 12;    // covers encoder, queue, core and display

    typedef struct packed {
        raw_inputs_t  drive;
        game_state_t  state;
        pos_t         pos;
        logic [15:0]  bcd;
        logic [15:0]  led;
    } row_t;

    logic         clk;
    logic         rst;
    raw_inputs_t  inputs;
    logic [15:0]  led;
    logic [15:0]  status_bcd;
    game_state_t  game_state;
    pos_t         player_pos;

    row_t   rows[$];
    string  row_names[$];
    bit     table_ready;
    int     mismatch_count;
    int     pass_rows;
    int     fail_rows;

    // expected play state while the table is built
    game_state_t  m_state;
    int           m_x;
    int           m_y;
    int           m_vol;
    int           m_score;
    int           m_health;

    game_top game_top_i (
        .clk        (clk),
        .rst        (rst),
        .inputs     (inputs),
        .led        (led),
        .status_bcd (status_bcd),
        .game_state (game_state),
        .player_pos (player_pos)
    );

    bind game_top game_props game_props_i (
        .clk        (clk),
        .rst        (rst),
        .out_ready  (q_ready),
        .fifo_count (cmd_fifo_i.count),
        .game_state (game_state),
        .led        (led)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    //============================================================
    // expected values from the game rules
    //============================================================
    function automatic raw_inputs_t press(input string name, input logic pause);
        raw_inputs_t v;
        v = '0;
        v.pause_sw = pause;
        case (name)
            "w":           v.key_w = 1'b1;
            "a":           v.key_a = 1'b1;
            "s":           v.key_s = 1'b1;
            "d":           v.key_d = 1'b1;
            "btn_up":      v.btn_up = 1'b1;
            "btn_down":    v.btn_down = 1'b1;
            "select":      v.btn_select = 1'b1;
            "back":        v.btn_back = 1'b1;
            "hit_enemy":   v.hit_enemy = 1'b1;
            "hit_shooter": v.hit_shooter = 1'b1;
            "hit_player":  v.hit_player = 1'b1;
            default:       ;    // nothing pressed
        endcase
        return v;
    endfunction

    // health digits then score digits, blank on win
    function automatic logic [15:0] bcd_of(input game_state_t st, input int health,
                                           input int score);
        if (st == game_win) return 16'h0000;
        return {4'(health / 10), 4'(health % 10), 4'(score / 10), 4'(score % 10)};
    endfunction

    function automatic logic [15:0] bar_of(input game_state_t st, input int vol);
        logic [15:0] v;
        v = '0;
        if (st == game_running || st == game_pause) begin
            for (int i = 0; i < vol; i++) v[i] = 1'b1;
        end
        return v;
    endfunction

    task automatic add_row(input string name, input logic pause);
        row_t r;
        r.drive = press(name, pause);
        r.state = m_state;
        r.pos.x = coord_t'(m_x);
        r.pos.y = coord_t'(m_y);
        r.bcd   = bcd_of(m_state, m_health, m_score);
        r.led   = bar_of(m_state, m_vol);
        rows.push_back(r);
        row_names.push_back((name == "") ? "none" : name);
    endtask

    task automatic build_table();
        m_state  = menu_idle;
        m_x      = PLAYER_START_X;
        m_y      = PLAYER_START_Y;
        m_vol    = VOL_RESET;
        m_score  = 0;
        m_health = HEALTH_START;
        add_row("", 1'b0);              // reset values
        add_row("btn_down", 1'b0);
        m_state = menu_tutorial;
        add_row("select", 1'b0);
        m_state = menu_idle;
        add_row("back", 1'b0);
        add_row("btn_up", 1'b0);
        m_state = game_running;
        add_row("select", 1'b0);
        // one step each way
        m_y = m_y - MOVE_STEP;
        add_row("w", 1'b0);
        m_y = m_y + MOVE_STEP;
        add_row("s", 1'b0);
        m_x = m_x - MOVE_STEP;
        add_row("a", 1'b0);
        m_x = m_x + MOVE_STEP;
        add_row("d", 1'b0);
        while (m_x > 30) begin
            m_x = m_x - MOVE_STEP;
            add_row("a", 1'b0);
        end
        repeat (10) begin               // stops at the left margin
            if (m_x - MOVE_STEP >= MOVE_STEP) m_x = m_x - MOVE_STEP;
            add_row("a", 1'b0);
        end
        repeat (3) begin
            if (m_vol < VOL_MAX) m_vol++;
            add_row("btn_up", 1'b0);
        end
        repeat (5) begin
            if (m_vol > VOL_MIN) m_vol--;
            add_row("btn_down", 1'b0);
        end
        m_state = game_pause;
        add_row("", 1'b1);
        add_row("d", 1'b1);             // move ignored while paused
        m_state = game_running;
        add_row("", 1'b0);
        m_score = 1;
        add_row("hit_enemy", 1'b0);
        m_score = 3;
        add_row("hit_shooter", 1'b0);
        m_score = 5;
        add_row("hit_shooter", 1'b0);
        m_score = 7;
        add_row("hit_shooter", 1'b0);
        m_score = 8;
        add_row("hit_enemy", 1'b0);
        m_score = 10;
        m_state = game_win;
        add_row("hit_shooter", 1'b0);
        m_state = menu_idle;
        add_row("back", 1'b0);
        // new game resets position, score and health
        m_state  = game_running;
        m_x      = PLAYER_START_X;
        m_y      = PLAYER_START_Y;
        m_score  = 0;
        m_health = HEALTH_START;
        add_row("select", 1'b0);
        repeat (25) begin
            m_health = m_health - PLAYER_DAMAGE;
            if (m_health <= 0) begin
                m_health = 0;
                m_state  = game_lose;
            end
            add_row("hit_player", 1'b0);
        end
        m_state = menu_idle;
        add_row("back", 1'b0);
    endtask

    //============================================================
    // row execution and checks
    //============================================================
    task automatic run_row(input int idx);
        row_t r;
        int   errs;
        r    = rows[idx];
        errs = 0;
        @(posedge clk);
        #1 inputs = r.drive;
        @(posedge clk);
        #1;
        inputs          = '0;
        inputs.pause_sw = r.drive.pause_sw;    // switch stays where the row put it
        repeat (ROW_CYCLES) @(posedge clk);
        #1;
        if (game_state !== r.state) begin
            $display("[ERROR] row %0d game_state expected %h got %h", idx, r.state,
                     game_state);
            errs++;
        end
        if (player_pos !== r.pos) begin
            $display("[ERROR] row %0d player_pos expected %h got %h", idx, r.pos,
                     player_pos);
            errs++;
        end
        if (status_bcd !== r.bcd) begin
            $display("[ERROR] row %0d status_bcd expected %h got %h", idx, r.bcd,
                     status_bcd);
            errs++;
        end
        if (led !== r.led) begin
            $display("[ERROR] row %0d led expected %h got %h", idx, r.led, led);
            errs++;
        end
        mismatch_count += errs;
        if (errs == 0) begin
            pass_rows++;
            $display("row %0d %s pause=%0b ok", idx, row_names[idx], r.drive.pause_sw);
        end else begin
            fail_rows++;
            $display("row %0d %s pause=%0b mismatch", idx, row_names[idx],
                     r.drive.pause_sw);
        end
    endtask

    initial begin
        inputs         = '0;
        rst            = 1'b1;
        mismatch_count = 0;
        pass_rows      = 0;
        fail_rows      = 0;
        table_ready    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("%0d rows, %0d passed, %0d failed, %0d mismatches", rows.size(),
                 pass_rows, fail_rows, mismatch_count);
        if (fail_rows == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit;
        wait (table_ready);
        limit = rows.size() * 14 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

/* flist.f */
design/game_pkg.sv
design/cmd_encoder.sv
design/cmd_fifo.sv
design/game_core.sv
design/status_display.sv
design/game_top.sv
verification/game_props.sv
verification/game_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the game testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module game_tb -o game_tb_sim \
    && ./obj_dir/game_tb_sim | tee /dev/stderr | grep -q "^Verification passed$" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
